// File: Bender.yml
package:
  name: call_unit

sources:
  - design/call_pkg.sv
  - design/call_target.sv
  - design/return_frame.sv
  - design/call_sequencer.sv
  - design/call_unit_top.sv
  - target: simulation
    files:
      - verification/call_unit_tb.sv

// File: design/call_pkg.sv
`default_nettype none

package call_pkg;

    typedef logic [3:0] nibble_t;

    // Program counter as bank, page and step
    typedef struct packed {
        logic       bank;
        logic [3:0] page;
        logic [7:0] step;
    } pc_t;

    // Return address as it sits on the stack
    typedef struct packed {
        nibble_t pcp;
        nibble_t pcsh;
        nibble_t pcsl;
    } frame_t;

    typedef struct packed {
        logic [3:0] major;
        logic [7:0] step;
    } call_view_t;

    typedef struct packed {
        logic [3:0] major;
        logic [3:0] minor;
        logic [3:0] sub;
    } misc_view_t;

    // One 12-bit word seen as CALL/CALZ or as a misc opcode
    typedef union packed {
        call_view_t call;
        misc_view_t misc;
    } instr_u;

    typedef enum logic [1:0] {
        op_none,
        op_call,
        op_calz,
        op_ret
    } op_e;

    localparam logic [3:0] MAJOR_CALL = 4'h4;
    localparam logic [3:0] MAJOR_CALZ = 4'h5;
    localparam logic [3:0] RET_MAJOR  = 4'hF;
    localparam logic [3:0] RET_MINOR  = 4'hD;
    localparam logic [3:0] RET_SUB    = 4'hF;

    localparam logic [7:0] SP_RESET  = 8'h44;
    localparam int         OP_CYCLES = 7;
    localparam int         CNT_W     = $clog2(OP_CYCLES + 1);
    localparam int         UPDATE_CYCLE = 5; // pc/sp update for RET, sp for calls

endpackage

`default_nettype wire

// File: design/call_sequencer.sv
`default_nettype none
`timescale 1ns/1ns

module call_sequencer (
    input  wire logic             clk,
    input  wire logic             arst_n,
    input  wire logic             instr_valid,
    input  wire call_pkg::op_e    op,
    input  wire call_pkg::pc_t    target,
    input  wire call_pkg::frame_t ret_nibbles,
    input  wire call_pkg::pc_t    return_pc,
    input  wire logic             pc_load,
    input  wire call_pkg::pc_t    pc_load_value,
    input  wire call_pkg::nibble_t mem_rdata,
    output logic                  accept_en,
    output call_pkg::pc_t         pc,
    output call_pkg::frame_t      pop_frame,
    output logic [7:0]            sp,
    output logic                  busy,
    output logic                  done,
    output logic                  illegal,
    output logic [7:0]            mem_addr,
    output call_pkg::nibble_t     mem_wdata,
    output logic                  mem_we,
    output logic                  mem_re
);
    import call_pkg::*;

    logic [CNT_W-1:0] cnt;     // Cycle number, 0 when idle
    op_e              op_q;
    op_e              cur_op;
    frame_t           push_q;  // Return frame held for pushes 2 and 3
    logic             is_push;
    logic             is_pop;
    logic             xfer;    // Stack access cycles 1 to 3

    // Op from call_target is only valid in cycle 1
    assign cur_op    = (cnt == CNT_W'(1)) ? op : op_q;
    assign is_push   = (cur_op == op_call) || (cur_op == op_calz);
    assign is_pop    = (cur_op == op_ret);
    assign busy      = (cnt != '0) && (cur_op != op_none);
    assign accept_en = !busy;
    assign done      = (cnt == CNT_W'(OP_CYCLES));
    assign illegal   = (cnt == CNT_W'(1)) && (op == op_none);
    assign xfer      = (cnt != '0) && (cnt <= CNT_W'(3));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= '0;
            op_q <= op_none;
        end else begin
            if (instr_valid && accept_en) begin
                cnt <= CNT_W'(1);
            end else if (busy && !done) begin
                cnt <= cnt + CNT_W'(1);
            end else begin
                cnt <= '0;          // Done or illegal word
            end
            if (cnt == CNT_W'(1)) begin
                op_q <= op;
            end else if (done) begin
                op_q <= op_none;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
            sp <= SP_RESET;
        end else begin
            if (is_push && cnt == CNT_W'(1)) begin
                pc <= target;       // Jump at end of cycle 1
            end else if (is_pop && cnt == CNT_W'(UPDATE_CYCLE)) begin
                pc <= return_pc;
            end else if (pc_load && !busy) begin
                pc <= pc_load_value;
            end
            if (busy && cnt == CNT_W'(UPDATE_CYCLE)) begin
                sp <= is_push ? sp - 8'd3 : sp + 8'd3;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_push && cnt == CNT_W'(1)) begin
            push_q <= ret_nibbles;
        end
        if (is_pop) begin
            case (cnt)
                CNT_W'(2): pop_frame.pcsl <= mem_rdata;  // Read data lags address by one
                CNT_W'(3): pop_frame.pcsh <= mem_rdata;
                CNT_W'(4): pop_frame.pcp  <= mem_rdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        mem_we    = 1'b0;
        mem_re    = 1'b0;
        mem_addr  = sp;
        mem_wdata = '0;
        if (xfer && is_push) begin
            mem_we   = 1'b1;
            mem_addr = sp - 8'(cnt);  // Push downwards, page first
            case (cnt)
                CNT_W'(1): mem_wdata = ret_nibbles.pcp;
                CNT_W'(2): mem_wdata = push_q.pcsh;
                default:   mem_wdata = push_q.pcsl;
            endcase
        end else if (xfer && is_pop) begin
            mem_re   = 1'b1;
            mem_addr = sp + 8'(cnt - CNT_W'(1));  // Pop upwards, pcsl first
        end
    end

    a_no_we_and_re: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_we && mem_re))
        else $error("Stack read and write in the same cycle");

    a_done_single: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done)
        else $error("Done held longer than one cycle");

    a_no_strobe_busy: assert property (@(posedge clk) disable iff (!arst_n)
        busy |-> !instr_valid)
        else $error("Instruction strobed while busy");

endmodule

`default_nettype wire

// File: design/call_target.sv
`default_nettype none
`timescale 1ns/1ns

module call_target (
    input  wire logic            clk,
    input  wire logic            arst_n,
    input  wire call_pkg::instr_u instr,
    input  wire logic            instr_valid,
    input  wire logic            accept_en,
    input  wire logic [3:0]      np,
    input  wire call_pkg::pc_t   pc,
    output call_pkg::op_e        op,
    output call_pkg::pc_t        target
);
    import call_pkg::*;

    logic accept;
    logic is_call;
    logic is_calz;
    logic is_ret;
    op_e  op_dec;
    pc_t  target_dec;

    assign accept  = instr_valid && accept_en;
    assign is_call = (instr.call.major == MAJOR_CALL); // Call view
    assign is_calz = (instr.call.major == MAJOR_CALZ);
    assign is_ret  = (instr.misc.major == RET_MAJOR) &&
                     (instr.misc.minor == RET_MINOR) &&
                     (instr.misc.sub == RET_SUB);  // Misc view

    always_comb begin
        if (is_call) begin
            op_dec = op_call;
        end else if (is_calz) begin
            op_dec = op_calz;
        end else if (is_ret) begin
            op_dec = op_ret;
        end else begin
            op_dec = op_none;  // Unknown word
        end
    end

    always_comb begin
        target_dec.bank = pc.bank;                // Bank never changes here
        target_dec.page = is_calz ? 4'h0 : np;
        target_dec.step = instr.call.step;
    end

    // Op is a one-cycle class pulse after acceptance
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op <= op_none;
        end else begin
            op <= accept ? op_dec : op_none;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            target <= target_dec;
        end
    end

    a_decode_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        instr_valid |-> $onehot0({is_call, is_calz, is_ret}))
        else $error("Instruction decodes to more than one class");

    a_op_after_accept: assert property (@(posedge clk) disable iff (!arst_n)
        (op != op_none) |-> $past(accept))
        else $error("Op class set without an accepted word");

endmodule

`default_nettype wire

// File: design/call_unit_top.sv
`default_nettype none
`timescale 1ns/1ns

module call_unit_top (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire call_pkg::instr_u  instr,
    input  wire logic              instr_valid,
    input  wire logic [3:0]        np,
    input  wire logic              pc_load,
    input  wire call_pkg::pc_t     pc_load_value,
    input  wire call_pkg::nibble_t mem_rdata,
    output wire call_pkg::pc_t     pc,
    output wire logic [7:0]        sp,
    output wire logic              busy,
    output wire logic              done,
    output wire logic              illegal,
    output wire logic [7:0]        mem_addr,
    output wire call_pkg::nibble_t mem_wdata,
    output wire logic              mem_we,
    output wire logic              mem_re
);
    import call_pkg::*;

    wire logic   accept_en;
    wire op_e    op;
    wire pc_t    target;
    wire frame_t ret_nibbles;
    wire frame_t pop_frame;
    wire pc_t    return_pc;

    call_target call_target_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr      (instr),
        .instr_valid(instr_valid),
        .accept_en  (accept_en),
        .np         (np),
        .pc         (pc),
        .op         (op),
        .target     (target)
    );

    return_frame return_frame_inst (
        .pc         (pc),
        .pop_frame  (pop_frame),
        .ret_nibbles(ret_nibbles),
        .return_pc  (return_pc)
    );

    call_sequencer call_sequencer_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .op           (op),
        .target       (target),
        .ret_nibbles  (ret_nibbles),
        .return_pc    (return_pc),
        .pc_load      (pc_load),
        .pc_load_value(pc_load_value),
        .mem_rdata    (mem_rdata),
        .accept_en    (accept_en),
        .pc           (pc),
        .pop_frame    (pop_frame),
        .sp           (sp),
        .busy         (busy),
        .done         (done),
        .illegal      (illegal),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_we       (mem_we),
        .mem_re       (mem_re)
    );

endmodule

`default_nettype wire

// File: design/return_frame.sv
`default_nettype none
`timescale 1ns/1ns

module return_frame (
    input  wire call_pkg::pc_t    pc,
    input  wire call_pkg::frame_t pop_frame,
    output call_pkg::frame_t      ret_nibbles,
    output call_pkg::pc_t         return_pc
);
    import call_pkg::*;

    logic [11:0] main_addr;
    logic [11:0] next_addr;

    // Page and step count as one 12-bit value
    assign main_addr = {pc.page, pc.step};
    assign next_addr = main_addr + 12'd1;  // Wraps inside the bank

    always_comb begin
        ret_nibbles.pcp  = next_addr[11:8];
        ret_nibbles.pcsh = next_addr[7:4];
        ret_nibbles.pcsl = next_addr[3:0];
    end

    // Popped frame carries no bank bit
    always_comb begin
        return_pc.bank = pc.bank;
        return_pc.page = pop_frame.pcp;
        return_pc.step = {pop_frame.pcsh, pop_frame.pcsl};
    end

endmodule

`default_nettype wire

// File: list.f
design/call_pkg.sv
design/call_target.sv
design/return_frame.sv
design/call_sequencer.sv
design/call_unit_top.sv
verification/call_unit_tb.sv

// File: verification/call_golden.txt
# name start_pc(- keeps state) np instr kind(C push, R pop, X illegal) exp_pc exp_sp
# writes: three pushed nibbles page first, or - when nothing is pushed
call_basic   1234 2 4AB C 12AB 41 235
ret_basic    -    0 FDF R 1235 44 -
call_bank    1234 A 444 C 1A44 41 235
calz_abc     1ABC 7 569 C 1069 3E ABD
calz_carry   05FF 0 5AB C 00AB 3B 600
call_carry   05FF 3 4AB C 03AB 38 600
ret_carry    -    0 FDF R 0600 3B -
illegal_word -    0 123 X 0600 3B -
illegal_ret  -    0 FDE X 0600 3B -
ret_calz     -    0 FDF R 0600 3E -
ret_bank     -    0 FDF R 0ABD 41 -
ret_first    -    0 FDF R 0235 44 -

// File: verification/call_unit_tb.sv
`default_nettype none
`timescale 1ns/1ns

module call_unit_tb;
    import call_pkg::*;

    typedef struct packed {
        logic [7:0]  kind;      // C push, R pop, X illegal word
        logic        load;
        logic [15:0] start_pc;
        logic [15:0] np_val;
        logic [15:0] word;
        logic [15:0] exp_pc;
        logic [15:0] exp_sp;
        logic [15:0] exp_wr;    // Three pushed nibbles, page first
    } vector_t;

    logic        clk;
    logic        arst_n;
    instr_u      instr;
    logic        instr_valid;
    logic [3:0]  np;
    logic        pc_load;
    pc_t         pc_load_value;
    nibble_t     mem_rdata;
    pc_t         pc;
    logic [7:0]  sp;
    logic        busy;
    logic        done;
    logic        illegal;
    logic [7:0]  mem_addr;
    nibble_t     mem_wdata;
    logic        mem_we;
    logic        mem_re;

    nibble_t     stack_mem [256];
    logic [11:0] wr_log [$];  // Address and nibble of each write
    logic [7:0]  rd_log [$];  // Address of each read
    vector_t     vecs [$];
    string       names [$];
    int          cycles = 0;
    int          limit = 0;
    int          test_errs = 0;
    int          passed = 0;
    int          failed = 0;

    call_unit_top call_unit_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Stack memory with one-cycle registered read
    always @(posedge clk) begin
        if (mem_we) begin
            stack_mem[mem_addr] <= mem_wdata;
            wr_log.push_back({mem_addr, mem_wdata});
        end
        if (mem_re) begin
            mem_rdata <= stack_mem[mem_addr];
            rd_log.push_back(mem_addr);
        end
    end

    task automatic compare_value(input string test, input string what,
                                 input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act) begin
            $display("** Error %s: %s expected %h, actual %h", test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic read_golden(output bit ok);
        int          fd;
        int          n;
        string       line;
        string       name;
        string       start_s;
        string       kind_s;
        string       wr_s;
        logic [15:0] np_v;
        logic [15:0] word_v;
        logic [15:0] pc_v;
        logic [15:0] sp_v;
        vector_t     v;
        fd = $fopen("verification/call_golden.txt", "r");
        ok = (fd != 0);
        while (ok && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %s %h %h %s %h %h %s",
                            name, start_s, np_v, word_v, kind_s, pc_v, sp_v, wr_s);
                if (n == 8) begin
                    v.kind     = kind_s.getc(0);
                    v.load     = (start_s != "-");  // Dash keeps the previous state
                    v.start_pc = 16'(start_s.atohex());
                    v.np_val   = np_v;
                    v.word     = word_v;
                    v.exp_pc   = pc_v;
                    v.exp_sp   = sp_v;
                    v.exp_wr   = 16'(wr_s.atohex());
                    names.push_back(name);
                    vecs.push_back(v);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        ok = ok && (vecs.size() > 0);
    endtask

    task automatic run_test(input int i);
        vector_t     v;
        int          k;
        logic [11:0] exp_wr;
        logic [7:0]  exp_ra;
        v = vecs[i];
        test_errs = 0;
        @(posedge clk);
        wr_log.delete();
        rd_log.delete();
        pc_load       <= v.load;
        pc_load_value <= v.start_pc[12:0];
        np            <= v.np_val[3:0];
        @(posedge clk);
        pc_load     <= 1'b0;
        instr       <= v.word[11:0];
        instr_valid <= 1'b1;
        @(posedge clk);  // Accepting edge
        instr_valid <= 1'b0;
        if (v.kind == "X") begin
            @(negedge clk);
            if (!illegal || busy || done) begin
                $display("%s: illegal did not pulse alone in cycle 1", names[i]);
                test_errs++;
            end
            @(negedge clk);
            if (illegal) begin
                $display("%s: illegal stayed high after cycle 1", names[i]);
                test_errs++;
            end
        end else begin
            k = 0;
            do begin
                @(negedge clk);
                k++;
                if (!busy) begin
                    $display("%s: busy was low in cycle %0d", names[i], k);
                    test_errs++;
                end
                if (illegal) begin
                    $display("%s: illegal pulsed for a valid word in cycle %0d", names[i], k);
                    test_errs++;
                end
            end while (!done && k < OP_CYCLES + 3);
            compare_value(names[i], "done cycle", OP_CYCLES, k);
        end
        compare_value(names[i], "pc", v.exp_pc, {3'b000, pc});
        compare_value(names[i], "sp", v.exp_sp, {8'h00, sp});
        if (v.kind == "C" && wr_log.size() == 3) begin
            for (int j = 0; j < 3; j++) begin
                exp_wr = {v.exp_sp[7:0] + 8'(2 - j), 4'(v.exp_wr >> (8 - 4 * j))};
                compare_value(names[i], "stack write", exp_wr, wr_log[j]);
            end
        end else if (wr_log.size() != ((v.kind == "C") ? 3 : 0)) begin
            $display("%s: wrong number of stack writes, %0d seen", names[i], wr_log.size());
            test_errs++;
        end
        if (v.kind == "R" && rd_log.size() == 3) begin
            for (int j = 0; j < 3; j++) begin
                exp_ra = v.exp_sp[7:0] - 8'(3 - j);  // Pops run upwards from the old sp
                compare_value(names[i], "stack read", exp_ra, rd_log[j]);
            end
        end else if (rd_log.size() != ((v.kind == "R") ? 3 : 0)) begin
            $display("%s: wrong number of stack reads, %0d seen", names[i], rd_log.size());
            test_errs++;
        end
        if (test_errs == 0) begin
            passed++;
            $display("PASS %s", names[i]);
        end else begin
            failed++;
            $display("FAIL %s with %0d errors", names[i], test_errs);
        end
    endtask

    initial begin
        bit ok;
        arst_n        = 1'b0;
        instr         = '0;
        instr_valid   = 1'b0;
        np            = '0;
        pc_load       = 1'b0;
        pc_load_value = '0;
        mem_rdata     = '0;
        for (int a = 0; a < 256; a++) begin
            stack_mem[a] = 4'(a ^ (a >> 4) ^ 9);  // Fill depends on both address nibbles
        end
        read_golden(ok);
        if (!ok) begin
            $display("No test vectors could be read from the golden file");
            $display("Simulation FAILED");
            $finish;
        end else begin
            limit = vecs.size() * (OP_CYCLES + 4) + 20;
            repeat (10) @(posedge clk);
            arst_n <= 1'b1;
            foreach (vecs[i]) begin
                run_test(i);
            end
            $display("%0d tests, %0d passed, %0d failed", vecs.size(), passed, failed);
            if (failed == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
